//--- fetch_predecode.f
verilog/predecode_pkg.sv
verilog/fetch_block_reg.sv
verilog/slot_predecoder.sv
verilog/redirect_checker.sv
verilog/fetch_predecode.sv
test/tb_fetch_predecode.sv

//--- Bender.yml
package:
  name: fetch_predecode

sources:
  - verilog/predecode_pkg.sv
  - verilog/fetch_block_reg.sv
  - verilog/slot_predecoder.sv
  - verilog/redirect_checker.sv
  - verilog/fetch_predecode.sv
  - target: test
    files:
      - test/tb_fetch_predecode.sv

//--- test/tb_fetch_predecode.sv
`timescale 1ns/1ps

module tb_fetch_predecode;
    import predecode_pkg::*;

    localparam int clk_period   = 8;
    localparam int sample_delay = 2;
    localparam int reset_cycles = 10;
    localparam int n_rows       = 12;
    localparam logic [31:0] beq_word = 32'h0000_0463;   // beq x0, x0, +8

    typedef struct packed {
        logic [7:0]  valid;
        logic [31:0] start;
        logic [3:0]  fsq;
        logic [7:0]  ipf;
        logic        taken;
        logic [2:0]  size;
        br_type_e    btype;
        logic [31:0] ptarget;
        logic [1:0]  n_sp;         // How many of the two special words are placed
        logic [2:0]  sp0_slot;
        logic [31:0] sp0_word;
        logic [2:0]  sp1_slot;
        logic [31:0] sp1_word;
        logic [3:0]  stall;        // Cycles of ibuf_full after the block is captured
        logic        flush;        // frontend_flush during the output cycle
        logic        exp_redir;
        logic [31:0] exp_target;
        logic [2:0]  exp_size;
        logic        exp_taken;
        ras_type_e   exp_ras;
        logic [7:0]  exp_en;
        logic [3:0]  exp_num;
    } table_row_t;

    logic         clk = 1'b0;
    logic         rst;
    logic         cache_en;
    fetch_block_t cache_block;
    logic         ibuf_full;
    logic         frontend_flush;
    logic         redirect_en;
    pd_redirect_t pd_redirect;
    ibuf_write_t  ibuf_wr;

    table_row_t   rows [n_rows];
    fetch_block_t cur_blk;
    logic [31:0]  rng_state = 32'd35741;
    int           errors = 0;
    int           cur_row = -1;

    fetch_predecode i_dut (
        .clk            (clk),
        .rst            (rst),
        .cache_en       (cache_en),
        .cache_block    (cache_block),
        .ibuf_full      (ibuf_full),
        .frontend_flush (frontend_flush),
        .redirect_en    (redirect_en),
        .pd_redirect    (pd_redirect),
        .ibuf_wr        (ibuf_wr)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] jal_word(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    // ALU words only, predicted not taken through the last slot
    function automatic fetch_block_t plain_block(logic [7:0] valid, logic [31:0] start);
        fetch_block_t blk;
        logic [31:0]  word;
        blk                   = '0;
        blk.en                = valid;
        blk.stream.start_addr = start;
        blk.stream.size       = 3'd7;
        for (int i = 0; i < block_inst_size; i++) begin
            word        = next_rand();
            blk.data[i] = {word[31:7], 7'b0110011};
        end
        return blk;
    endfunction

    function automatic fetch_block_t build_block(table_row_t r);
        fetch_block_t blk;
        blk                    = plain_block(r.valid, r.start);
        blk.fsq_idx            = r.fsq;
        blk.ipf                = r.ipf;
        blk.stream.taken       = r.taken;
        blk.stream.size        = r.size;
        blk.stream.branch_type = r.btype;
        blk.stream.ras_type    = NONE;
        blk.stream.target      = r.ptarget;
        if (r.n_sp > 0) begin
            blk.data[r.sp0_slot] = r.sp0_word;
        end
        if (r.n_sp > 1) begin
            blk.data[r.sp1_slot] = r.sp1_word;
        end
        return blk;
    endfunction

    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        assert (act === exp) else begin
            $display("[ERROR] row %0d %s: expected %h, actual %h", cur_row, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_idle();
        check_val("redirect_en", 32'(redirect_en), 32'h0);
        check_val("ibuf_wr.en", 32'(ibuf_wr.en), 32'h0);
    endtask

    task automatic check_outputs(input table_row_t r);
        check_val("redirect_en", 32'(redirect_en), 32'(r.exp_redir));
        if (r.exp_redir) begin
            check_val("pd_redirect.target", pd_redirect.target, r.exp_target);
            check_val("pd_redirect.size", 32'(pd_redirect.size), 32'(r.exp_size));
            check_val("pd_redirect.taken", 32'(pd_redirect.taken), 32'(r.exp_taken));
            check_val("pd_redirect.direct", 32'(pd_redirect.direct), 32'(r.exp_taken));
            check_val("pd_redirect.ras_type", 32'(pd_redirect.ras_type), 32'(r.exp_ras));
            // A taken redirect is always a jal, a fall-through keeps the predicted type
            check_val("pd_redirect.branch_type", 32'(pd_redirect.branch_type),
                      32'(r.exp_taken ? DIRECT : r.btype));
            check_val("pd_redirect.fsq_idx", 32'(pd_redirect.fsq_idx), 32'(r.fsq));
            check_val("pd_redirect.start_addr", pd_redirect.start_addr, r.start);
        end
        check_val("ibuf_wr.en", 32'(ibuf_wr.en), 32'(r.exp_en));
        check_val("ibuf_wr.num", 32'(ibuf_wr.num), 32'(r.exp_num));
        check_val("ibuf_wr.fsq_idx", 32'(ibuf_wr.fsq_idx), 32'(r.fsq));
        check_val("ibuf_wr.iam", 32'(ibuf_wr.iam), 32'(r.start[1:0] != 2'b00));
        check_val("ibuf_wr.ipf", 32'(ibuf_wr.ipf), 32'(r.ipf));
        for (int i = 0; i < block_inst_size; i++) begin
            check_val($sformatf("ibuf_wr.inst[%0d]", i), ibuf_wr.inst[i], cur_blk.data[i]);
        end
    endtask

    // Columns are valid, start, fsq, ipf, taken, size, type, target, then the special
    // words with their slots, then stall, flush and the expected outputs
    task automatic fill_table();
        rows[0]  = '{8'hFF, 32'h1000, 4'h1, 8'h00, 1'b0, 3'd7, CONDITION, 32'h0,
                     2'd0, 3'd0, 32'h0, 3'd0, 32'h0,
                     4'd0, 1'b0, 1'b0, 32'h0, 3'd0, 1'b0, NONE, 8'hFF, 4'd8};
        rows[1]  = '{8'h3F, 32'h2002, 4'h2, 8'h24, 1'b0, 3'd5, CONDITION, 32'h0,
                     2'd0, 3'd0, 32'h0, 3'd0, 32'h0,
                     4'd0, 1'b0, 1'b0, 32'h0, 3'd0, 1'b0, NONE, 8'h3F, 4'd6};
        rows[2]  = '{8'hFF, 32'h4000, 4'h3, 8'h00, 1'b0, 3'd7, CONDITION, 32'h0,
                     2'd1, 3'd3, jal_word(5'd0, 21'h000100), 3'd0, 32'h0,
                     4'd0, 1'b0, 1'b1, 32'h410C, 3'd3, 1'b1, NONE, 8'h0F, 4'd4};
        rows[3]  = '{8'hFF, 32'h5000, 4'h4, 8'h00, 1'b1, 3'd6, CONDITION, 32'h5100,
                     2'd2, 3'd3, jal_word(5'd0, 21'h1FFFC0), 3'd6, beq_word,
                     4'd0, 1'b0, 1'b1, 32'h4FCC, 3'd3, 1'b1, NONE, 8'h0F, 4'd4};
        rows[4]  = '{8'hFF, 32'h6000, 4'h5, 8'h00, 1'b0, 3'd7, CONDITION, 32'h0,
                     2'd1, 3'd0, jal_word(5'd1, 21'h000800), 3'd0, 32'h0,
                     4'd0, 1'b0, 1'b1, 32'h6800, 3'd0, 1'b1, PUSH, 8'h01, 4'd1};
        rows[5]  = '{8'h1F, 32'h7000, 4'h6, 8'h00, 1'b1, 3'd4, INDIRECT, 32'h0,
                     2'd1, 3'd4, jalr_word(5'd0, 5'd1, 12'h000), 3'd0, 32'h0,
                     4'd0, 1'b0, 1'b0, 32'h0, 3'd0, 1'b0, NONE, 8'h1F, 4'd5};
        rows[6]  = '{8'hFF, 32'h8000, 4'h7, 8'h00, 1'b1, 3'd2, CONDITION, 32'h8100,
                     2'd0, 3'd0, 32'h0, 3'd0, 32'h0,
                     4'd0, 1'b0, 1'b1, 32'h800C, 3'd2, 1'b0, NONE, 8'h07, 4'd3};
        rows[7]  = '{8'hFF, 32'h9000, 4'h8, 8'h81, 1'b0, 3'd7, CONDITION, 32'h0,
                     2'd1, 3'd5, jal_word(5'd5, 21'h000020), 3'd0, 32'h0,
                     4'd3, 1'b0, 1'b1, 32'h9034, 3'd5, 1'b1, PUSH, 8'h3F, 4'd6};
        rows[8]  = '{8'hF0, 32'hA000, 4'h9, 8'h00, 1'b0, 3'd7, CONDITION, 32'h0,
                     2'd0, 3'd0, 32'h0, 3'd0, 32'h0,
                     4'd2, 1'b0, 1'b0, 32'h0, 3'd0, 1'b0, NONE, 8'hF0, 4'd4};
        rows[9]  = '{8'hFF, 32'hB000, 4'hA, 8'h00, 1'b0, 3'd7, CONDITION, 32'h0,
                     2'd0, 3'd0, 32'h0, 3'd0, 32'h0,
                     4'd0, 1'b1, 1'b0, 32'h0, 3'd0, 1'b0, NONE, 8'hFF, 4'd8};
        rows[10] = '{8'hFF, 32'hC000, 4'hB, 8'h00, 1'b1, 3'd2, DIRECT, 32'hC100,
                     2'd1, 3'd2, jal_word(5'd0, 21'h000040), 3'd0, 32'h0,
                     4'd0, 1'b0, 1'b1, 32'hC048, 3'd2, 1'b1, NONE, 8'h07, 4'd3};
        rows[11] = '{8'hFF, 32'hC000, 4'hC, 8'h00, 1'b1, 3'd2, DIRECT, 32'hC048,
                     2'd1, 3'd2, jal_word(5'd0, 21'h000040), 3'd0, 32'h0,
                     4'd0, 1'b0, 1'b0, 32'h0, 3'd0, 1'b0, NONE, 8'hFF, 4'd8};
    endtask

    task automatic run_row(input int idx);
        table_row_t r;
        r       = rows[idx];
        cur_row = idx;
        cur_blk = build_block(r);
        @(negedge clk);
        cache_en       = 1'b1;
        cache_block    = cur_blk;
        ibuf_full      = 1'b0;
        frontend_flush = 1'b0;
        if (r.stall > 0) begin
            @(negedge clk);
            ibuf_full   = 1'b1;
            cache_block = plain_block(8'h55, 32'hF000);   // Offered while the held one waits
            #(sample_delay);
            check_idle();
            for (int s = 1; s < r.stall; s++) begin
                @(negedge clk);
                #(sample_delay);
                check_idle();
            end
        end
        @(negedge clk);
        ibuf_full      = 1'b0;
        cache_block    = plain_block(8'hFF, 32'hE000);
        frontend_flush = r.flush;
        #(sample_delay);
        check_outputs(r);
        @(negedge clk);
        cache_en       = 1'b0;
        frontend_flush = 1'b0;
        #(sample_delay);
        // The follow-up block survives only without a redirect or flush at its edge
        check_val("ibuf_wr.en of next block", 32'(ibuf_wr.en),
                  (r.exp_redir || r.flush) ? 32'h0 : 32'hFF);
    endtask

    initial begin
        rst            = 1'b1;
        cache_en       = 1'b0;
        cache_block    = '0;
        ibuf_full      = 1'b0;
        frontend_flush = 1'b0;
        fill_table();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #(sample_delay);
        check_idle();
        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        $display("Table of %0d rows done with %0d errors", n_rows, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #((n_rows * 20 + reset_cycles) * clk_period);
        $display("Timeout: the stimulus table did not complete in the time allowed");
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- verilog/fetch_predecode.sv
`timescale 1ns/1ps

module fetch_predecode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cache_en,
    input  predecode_pkg::fetch_block_t  cache_block,
    input  logic                         ibuf_full,
    input  logic                         frontend_flush,
    output logic                         redirect_en,
    output predecode_pkg::pd_redirect_t  pd_redirect,
    output predecode_pkg::ibuf_write_t   ibuf_wr
);
    import predecode_pkg::*;

    fetch_block_t                     blk_q;
    logic                             flush;
    slot_t [block_inst_size-1:0]      slots;
    pd_bundle_t [block_inst_size-1:0] bundles;

    // Our own redirect drops the block arriving behind it
    assign flush = frontend_flush | redirect_en;

    fetch_block_reg i_block_reg (
        .clk         (clk),
        .rst         (rst),
        .cache_en    (cache_en),
        .cache_block (cache_block),
        .ibuf_full   (ibuf_full),
        .flush       (flush),
        .blk_q       (blk_q),
        .blk_valid   (),
        .slots       (slots)
    );

    for (genvar i = 0; i < block_inst_size; i++) begin : g_slot
        slot_predecoder i_slot_pd (
            .slot   (slots[i]),
            .bundle (bundles[i])
        );
    end

    redirect_checker i_checker (
        .blk_q       (blk_q),
        .bundles     (bundles),
        .ibuf_full   (ibuf_full),
        .redirect_en (redirect_en),
        .pd_redirect (pd_redirect),
        .ibuf_wr     (ibuf_wr)
    );

endmodule

//--- verilog/redirect_checker.sv
`timescale 1ns/1ps

module redirect_checker (
    input  predecode_pkg::fetch_block_t  blk_q,
    input  predecode_pkg::pd_bundle_t [predecode_pkg::block_inst_size-1:0] bundles,
    input  logic                         ibuf_full,
    output logic                         redirect_en,
    output predecode_pkg::pd_redirect_t  pd_redirect,
    output predecode_pkg::ibuf_write_t   ibuf_wr
);
    import predecode_pkg::*;

    logic [block_inst_size-1:0]  jump_en;
    logic                        any_jump;
    logic [block_inst_width-1:0] sel;
    logic [block_inst_width-1:0] tail;
    logic [block_inst_width-1:0] cut;
    logic [block_inst_width:0]   tail_cnt;
    pd_bundle_t                  tail_bundle;
    pd_bundle_t                  sel_bundle;
    logic                        false_hit;
    logic                        mismatch;
    logic [block_inst_size-1:0]  cut_mask;
    logic [block_inst_size-1:0]  wr_en;
    logic [block_inst_width:0]   wr_num;

    for (genvar i = 0; i < block_inst_size; i++) begin : g_jump
        assign jump_en[i] = blk_q.en[i] & bundles[i].direct;
    end

    assign any_jump = |jump_en;

    // Lowest valid jal in the block
    always_comb begin
        sel = '0;
        for (int i = block_inst_size - 1; i >= 0; i--) begin
            if (jump_en[i]) begin
                sel = block_inst_width'(i);
            end
        end
    end

    assign tail        = blk_q.stream.size;
    assign tail_cnt    = {1'b0, tail} + 1'b1;
    assign tail_bundle = bundles[tail];
    assign sel_bundle  = bundles[sel];

    // Predicted taken on something that decodes as a plain instruction
    assign false_hit = blk_q.en[0] & blk_q.stream.taken & ~tail_bundle.branch;

    always_comb begin
        mismatch = 1'b0;
        if (any_jump) begin
            mismatch = ~blk_q.stream.taken
                     | (tail != sel)
                     | (tail_bundle.br_type != blk_q.stream.branch_type)
                     | (tail_bundle.direct & (tail_bundle.target != blk_q.stream.target));
        end
    end

    assign redirect_en = (mismatch | false_hit) & ~ibuf_full;

    always_comb begin
        pd_redirect.fsq_idx    = blk_q.fsq_idx;
        pd_redirect.start_addr = blk_q.stream.start_addr;
        if (false_hit) begin
            // Resume at the fall-through of the predicted tail
            pd_redirect.direct      = 1'b0;
            pd_redirect.taken       = 1'b0;
            pd_redirect.size        = tail;
            pd_redirect.branch_type = blk_q.stream.branch_type;
            pd_redirect.ras_type    = NONE;
            pd_redirect.target      = blk_q.stream.start_addr
                                    + vaddr_size'({tail_cnt, 2'b00});
        end else begin
            pd_redirect.direct      = 1'b1;
            pd_redirect.taken       = 1'b1;
            pd_redirect.size        = sel;
            pd_redirect.branch_type = DIRECT;
            pd_redirect.ras_type    = sel_bundle.ras_type;
            pd_redirect.target      = sel_bundle.target;
        end
    end

    assign cut = false_hit ? tail : sel;

    always_comb begin
        for (int i = 0; i < block_inst_size; i++) begin
            cut_mask[i] = block_inst_width'(i) <= cut;
        end
    end

    always_comb begin
        if (ibuf_full) begin
            wr_en = '0;
        end else if (redirect_en) begin
            wr_en = blk_q.en & cut_mask;   // Slots past the cut belong to the wrong path
        end else begin
            wr_en = blk_q.en;
        end
    end

    always_comb begin
        wr_num = '0;
        for (int i = 0; i < block_inst_size; i++) begin
            wr_num = wr_num + (block_inst_width + 1)'(wr_en[i]);
        end
    end

    always_comb begin
        ibuf_wr.en      = wr_en;
        ibuf_wr.num     = wr_num;
        ibuf_wr.inst    = blk_q.data;
        ibuf_wr.fsq_idx = blk_q.fsq_idx;
        ibuf_wr.iam     = |blk_q.stream.start_addr[1:0];
        ibuf_wr.ipf     = blk_q.ipf;
    end

endmodule

//--- verilog/slot_predecoder.sv
`timescale 1ns/1ps

module slot_predecoder (
    input  predecode_pkg::slot_t      slot,
    output predecode_pkg::pd_bundle_t bundle
);
    import predecode_pkg::*;

    inst_word_u            word;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_cond;
    logic                  rd_link;
    logic                  rs1_link;
    logic [vaddr_size-1:0] j_imm;
    ras_type_e             link_ras;

    assign word = slot.inst;

    assign is_jal  = word.j_fmt.opcode == opcode_jal;
    assign is_jalr = (word.i_fmt.opcode == opcode_jalr) && (word.i_fmt.funct3 == 3'b000);
    assign is_cond = word.i_fmt.opcode == opcode_branch;

    assign rd_link  = (word.j_fmt.rd == link_ra) || (word.j_fmt.rd == link_t0);
    assign rs1_link = (word.i_fmt.rs1 == link_ra) || (word.i_fmt.rs1 == link_t0);

    // J immediate, sign extended to the address width
    assign j_imm = {
        {(vaddr_size - 21){word.j_fmt.imm20}},
        word.j_fmt.imm20,
        word.j_fmt.imm19_12,
        word.j_fmt.imm11,
        word.j_fmt.imm10_1,
        1'b0
    };

    always_comb begin
        case ({rd_link, rs1_link})
            2'b01:   link_ras = POP;
            2'b10:   link_ras = PUSH;
            2'b11:   link_ras = POP_PUSH;
            default: link_ras = NONE;
        endcase
    end

    always_comb begin
        bundle.branch = is_jal | is_jalr | is_cond;
        bundle.direct = is_jal;
        bundle.target = slot.addr + j_imm;   // Only meaningful for jal

        if (is_jal) begin
            bundle.br_type  = DIRECT;
            bundle.ras_type = rd_link ? PUSH : NONE;
        end else if (is_jalr) begin
            bundle.br_type  = INDIRECT;
            bundle.ras_type = link_ras;
        end else begin
            bundle.br_type  = CONDITION;
            bundle.ras_type = NONE;
        end
    end

endmodule

//--- verilog/fetch_block_reg.sv
`timescale 1ns/1ps

module fetch_block_reg (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cache_en,
    input  predecode_pkg::fetch_block_t  cache_block,
    input  logic                         ibuf_full,
    input  logic                         flush,
    output predecode_pkg::fetch_block_t  blk_q,
    output logic                         blk_valid,
    output predecode_pkg::slot_t [predecode_pkg::block_inst_size-1:0] slots
);
    import predecode_pkg::*;

    fetch_block_t blk_d;   // Raw block as captured from the cache

    // A flush wins over the stall so a redirect always drops the incoming block
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blk_valid <= 1'b0;
        end else if (flush) begin
            blk_valid <= 1'b0;
        end else if (!ibuf_full) begin
            blk_valid <= cache_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!ibuf_full) begin
            blk_d <= cache_block;
        end
    end

    // Valid mask only counts while a block is actually held
    always_comb begin
        blk_q    = blk_d;
        blk_q.en = blk_d.en & {block_inst_size{blk_valid}};
    end

    // Each slot sees its own word and the address it was fetched from
    for (genvar i = 0; i < block_inst_size; i++) begin : g_slot
        assign slots[i].inst = blk_d.data[i];
        assign slots[i].addr = blk_d.stream.start_addr + vaddr_size'(i * 4);
    end

endmodule

//--- verilog/predecode_pkg.sv
package predecode_pkg;

    localparam int block_inst_size  = 8;
    localparam int block_inst_width = 3;
    localparam int vaddr_size       = 32;
    localparam int fsq_idx_width    = 4;

    // Major opcodes seen by the pre-decoder
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;

    // Link registers per the RISC-V calling convention
    localparam logic [4:0] link_ra = 5'd1;
    localparam logic [4:0] link_t0 = 5'd5;

    typedef enum logic [1:0] {
        CONDITION = 2'd0,
        DIRECT    = 2'd1,
        INDIRECT  = 2'd2
    } br_type_e;

    typedef enum logic [1:0] {
        NONE     = 2'd0,
        PUSH     = 2'd1,
        POP      = 2'd2,
        POP_PUSH = 2'd3
    } ras_type_e;

    typedef struct packed {
        logic [vaddr_size-1:0]       start_addr;
        logic [block_inst_width-1:0] size;         // Index of the last slot in the stream
        logic                        taken;
        br_type_e                    branch_type;
        ras_type_e                   ras_type;
        logic [vaddr_size-1:0]       target;
    } fetch_stream_t;

    typedef struct packed {
        logic [block_inst_size-1:0]       en;
        logic [fsq_idx_width-1:0]         fsq_idx;
        fetch_stream_t                    stream;
        logic [block_inst_size-1:0][31:0] data;
        logic [block_inst_size-1:0]       ipf;
    } fetch_block_t;

    typedef struct packed {
        logic [31:0]           inst;
        logic [vaddr_size-1:0] addr;
    } slot_t;

    typedef struct packed {
        logic                  branch;   // Any jal, jalr or conditional branch
        logic                  direct;
        br_type_e              br_type;
        ras_type_e             ras_type;
        logic [vaddr_size-1:0] target;
    } pd_bundle_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // The same instruction word seen as a jal and as a jalr
    typedef union packed {
        j_fmt_t j_fmt;
        i_fmt_t i_fmt;
    } inst_word_u;

    typedef struct packed {
        logic [fsq_idx_width-1:0]    fsq_idx;
        logic                        direct;
        logic                        taken;
        logic [vaddr_size-1:0]       start_addr;
        logic [block_inst_width-1:0] size;
        br_type_e                    branch_type;
        ras_type_e                   ras_type;
        logic [vaddr_size-1:0]       target;
    } pd_redirect_t;

    typedef struct packed {
        logic [block_inst_size-1:0]       en;
        logic [block_inst_width:0]        num;
        logic [block_inst_size-1:0][31:0] inst;
        logic [fsq_idx_width-1:0]         fsq_idx;
        logic                             iam;     // Start address not word aligned
        logic [block_inst_size-1:0]       ipf;
    } ibuf_write_t;

endpackage
